// ==== logic/memSubsys_config.svh ====
`ifndef MEMSUBSYS_CONFIG_SVH
`define MEMSUBSYS_CONFIG_SVH

// Byte address into the data RAM.
`define ADDR_W 17

`define DATA_W 32

// Byte count of one access, 1, 2 or 4.
`define LEN_W 3

// Tag carried by a request to its response.
`define TAG_W 4

`define QUEUE_DEPTH 4

`define RAM_BYTES (1 << `ADDR_W)

`endif

// ==== logic/memPkg.sv ====
`include "memSubsys_config.svh"

package memPkg;

    // Tagged request from the core side.
    typedef struct packed {
        logic                isStore;
        logic [`ADDR_W-1:0]  addr;
        logic [`DATA_W-1:0]  data;
        logic [`LEN_W-1:0]   len;
        logic [`TAG_W-1:0]   tag;
    } memReq_t;

    // Command to the controller, without tag.
    typedef struct packed {
        logic                isStore;
        logic [`ADDR_W-1:0]  addr;
        logic [`DATA_W-1:0]  data;
        logic [`LEN_W-1:0]   len;
    } memCmd_t;

    typedef struct packed {
        logic [`DATA_W-1:0]  data;   // Zero for stores.
        logic [`TAG_W-1:0]   tag;
    } memResp_t;

    typedef enum logic [1:0] {
        ctrlIdle,
        ctrlXfer,   // One byte per cycle.
        ctrlDone
    } ctrlState_t;

endpackage

// ==== logic/loadStoreQueue.sv ====
`timescale 1ns/1ps
`include "memSubsys_config.svh"

module loadStoreQueue import memPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rdy,

    input  logic     reqEn,
    input  memReq_t  req,
    output logic     queueFull,

    input  logic     portReady,
    output logic     issueEn,
    output memReq_t  issueReq,

    input  logic     doneEn,
    input  memResp_t doneResp,
    output logic     respEn,
    output memResp_t resp
);

    localparam int PtrW = $clog2(`QUEUE_DEPTH);
    localparam int CntW = $clog2(`QUEUE_DEPTH + 1);

    memReq_t entries [`QUEUE_DEPTH];

    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;

    logic push;
    logic pop;
    logic notEmpty;

    assign notEmpty  = (count != '0);
    assign queueFull = (count == CntW'(`QUEUE_DEPTH));

    // A request sent while full is dropped.
    assign push = rdy && reqEn && !queueFull;

    // Head goes out as soon as the port has room.
    assign issueEn  = rdy && portReady && notEmpty;
    assign issueReq = entries[rdPtr];
    assign pop      = issueEn;

    // Completions leave in the cycle the port reports them.
    assign respEn = rdy && doneEn;
    assign resp   = doneResp;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                if (wrPtr == PtrW'(`QUEUE_DEPTH - 1)) begin
                    wrPtr <= '0;
                end else begin
                    wrPtr <= wrPtr + 1'b1;
                end
            end

            if (pop) begin
                if (rdPtr == PtrW'(`QUEUE_DEPTH - 1)) begin
                    rdPtr <= '0;
                end else begin
                    rdPtr <= rdPtr + 1'b1;
                end
            end

            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;   // Push and pop cancel.
                end
            endcase
        end
    end

endmodule

// ==== logic/dataPort.sv ====
`timescale 1ns/1ps
`include "memSubsys_config.svh"

module dataPort import memPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,

    input  logic              issueEn,
    input  memReq_t           issueReq,
    output logic              portReady,

    output logic              memEn,
    output memCmd_t           memCmd,
    input  logic              memBusy,
    input  logic              memDone,
    input  logic [`DATA_W-1:0] memData,

    output logic              doneEn,
    output memResp_t          doneResp
);

    memReq_t entry;
    logic    occupied;
    logic    issued;

    assign portReady = !occupied;

    // Sent once per entry, and only to an idle controller.
    assign memEn = rdy && occupied && !issued && !memBusy;

    assign memCmd.isStore = entry.isStore;
    assign memCmd.addr    = entry.addr;
    assign memCmd.data    = entry.data;
    assign memCmd.len     = entry.len;

    always_ff @(posedge clk) begin
        if (rdy && issueEn) begin
            entry <= issueReq;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && memDone) begin
            doneResp.data <= memData;
            doneResp.tag  <= entry.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
            issued   <= 1'b0;
            doneEn   <= 1'b0;
        end else if (rdy) begin
            doneEn <= memDone;

            if (memEn) begin
                issued <= 1'b1;
            end

            if (memDone) begin
                occupied <= 1'b0;   // Entry free again.
                issued   <= 1'b0;
            end

            if (issueEn) begin
                occupied <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/memCtrl.sv ====
`timescale 1ns/1ps
`include "memSubsys_config.svh"

module memCtrl import memPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,

    input  logic               memEn,
    input  memCmd_t            memCmd,
    output logic               memBusy,
    output logic               memDone,
    output logic [`DATA_W-1:0] memData,

    output logic               ramWe,
    output logic [`ADDR_W-1:0] ramAddr,
    output logic [7:0]         ramWdata,
    input  logic [7:0]         ramRdata
);

    ctrlState_t state;
    memCmd_t    cmd;

    logic [`LEN_W-1:0] cnt;
    logic              lastByte;
    logic              rdPending;
    logic [1:0]        wrLane;
    logic [1:0]        rdLane;
    logic              accept;

    assign accept   = rdy && memEn && (state == ctrlIdle);
    assign memBusy  = (state != ctrlIdle);
    assign lastByte = (cnt + 1'b1) == cmd.len;

    assign wrLane = cnt[1:0];
    assign rdLane = 2'(cnt - 1'b1);   // Byte read on the previous access.

    // Byte k of the access goes to addr+k.
    assign ramAddr  = cmd.addr + `ADDR_W'(cnt);
    assign ramWdata = cmd.data[{wrLane, 3'b000} +: 8];
    assign ramWe    = rdy && (state == ctrlXfer) && cmd.isStore;

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd     <= memCmd;
            memData <= '0;   // Upper lanes stay zero.
        end else if (rdPending) begin
            memData[{rdLane, 3'b000} +: 8] <= ramRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ctrlIdle;
            cnt       <= '0;
            memDone   <= 1'b0;
            rdPending <= 1'b0;
        end else begin
            // RAM data is taken on the next edge, stalled or not.
            rdPending <= rdy && (state == ctrlXfer) && !cmd.isStore;

            if (rdy) begin
                memDone <= 1'b0;

                case (state)
                    ctrlIdle: begin
                        if (memEn) begin
                            state <= ctrlXfer;
                            cnt   <= '0;
                        end
                    end
                    ctrlXfer: begin
                        cnt <= cnt + 1'b1;
                        if (lastByte) begin
                            state <= ctrlDone;
                        end
                    end
                    ctrlDone: begin
                        memDone <= 1'b1;   // Last read byte is in.
                        state   <= ctrlIdle;
                    end
                    default: begin
                        state <= ctrlIdle;
                    end
                endcase
            end
        end
    end

endmodule

// ==== logic/byteRam.sv ====
`timescale 1ns/1ps
`include "memSubsys_config.svh"

module byteRam (
    input  logic               clk,
    input  logic               we,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [7:0]         wdata,
    output logic [7:0]         rdata
);

    logic [7:0] mem [`RAM_BYTES];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Old data on a write to the same address.
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

// ==== logic/memSubsys.sv ====
`timescale 1ns/1ps
`include "memSubsys_config.svh"

module memSubsys import memPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rdy,

    input  logic     reqEn,
    input  memReq_t  req,
    output logic     queueFull,

    output logic     respEn,
    output memResp_t resp
);

    logic               portReady;
    logic               issueEn;
    memReq_t            issueReq;
    logic               doneEn;
    memResp_t           doneResp;

    logic               memEn;
    memCmd_t            memCmd;
    logic               memBusy;
    logic               memDone;
    logic [`DATA_W-1:0] memData;

    logic               ramWe;
    logic [`ADDR_W-1:0] ramAddr;
    logic [7:0]         ramWdata;
    logic [7:0]         ramRdata;

    loadStoreQueue lsQueue (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .reqEn     (reqEn),
        .req       (req),
        .queueFull (queueFull),
        .portReady (portReady),
        .issueEn   (issueEn),
        .issueReq  (issueReq),
        .doneEn    (doneEn),
        .doneResp  (doneResp),
        .respEn    (respEn),
        .resp      (resp)
    );

    dataPort dPort (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .issueEn   (issueEn),
        .issueReq  (issueReq),
        .portReady (portReady),
        .memEn     (memEn),
        .memCmd    (memCmd),
        .memBusy   (memBusy),
        .memDone   (memDone),
        .memData   (memData),
        .doneEn    (doneEn),
        .doneResp  (doneResp)
    );

    memCtrl mCtrl (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .memEn    (memEn),
        .memCmd   (memCmd),
        .memBusy  (memBusy),
        .memDone  (memDone),
        .memData  (memData),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    byteRam bRam (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

// ==== tests/memSubsysChecker.sv ====
`timescale 1ns/1ps
`include "memSubsys_config.svh"

module memSubsysChecker import memPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              queueFull,
    input  logic              respEn,
    input  memResp_t          resp,
    input  logic              expEn,
    input  memResp_t          expResp,
    input  logic [`LEN_W-1:0] expLen,
    input  logic              finalize,
    output int                pending,
    output int                errCount,
    output logic              reportDone
);

    memResp_t expQ [$];

    int   cycle       = 0;
    int   firstAccept = -1;
    int   firstLen    = 0;
    int   testNum     = 0;
    int   passCount   = 0;
    int   failCount   = 0;
    int   pendingCnt  = 0;
    logic sawFull     = 1'b0;
    logic reported    = 1'b0;

    assign pending    = pendingCnt;
    assign errCount   = failCount;
    assign reportDone = reported;

    task automatic checkResponse();
        memResp_t want;
        logic     ok;
        int       latency;
        if (expQ.size() == 0) begin
            $display("unexpected response with tag 0x%h at cycle %0d", resp.tag, cycle);
            failCount++;
        end else begin
            want = expQ.pop_front();
            ok   = 1'b1;
            if (resp.tag !== want.tag) begin
                $display("[FAIL] resp.tag exp 0x%h got 0x%h (test %0d)",
                         want.tag, resp.tag, testNum);
                ok = 1'b0;
            end
            if (resp.data !== want.data) begin
                $display("[FAIL] resp.data exp 0x%08h got 0x%08h (test %0d)",
                         want.data, resp.data, testNum);
                ok = 1'b0;
            end
            // First lone request on an idle pipeline.
            latency = cycle - firstAccept - 1;
            if (testNum == 0 && latency != firstLen + 4) begin
                $display("[FAIL] respEn latency exp 0x%0h got 0x%0h (test 0)",
                         firstLen + 4, latency);
                ok = 1'b0;
            end
            if (ok) begin
                passCount++;
                $display("PASS test %0d tag 0x%h data 0x%08h", testNum, resp.tag, resp.data);
            end else begin
                failCount++;
            end
            testNum++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            cycle = cycle + 1;
            if (queueFull) begin
                sawFull = 1'b1;
            end
            // A full queue holds that many requests still waiting for a response.
            if (queueFull && expQ.size() < `QUEUE_DEPTH) begin
                $display("queueFull is high with only %0d request(s) outstanding at cycle %0d",
                         expQ.size(), cycle);
                failCount++;
            end
            if (respEn && !rdy) begin
                $display("respEn is high while rdy is low at cycle %0d", cycle);
                failCount++;
            end
            if (respEn) begin
                checkResponse();
            end
            if (expEn) begin
                if (firstAccept < 0) begin
                    firstAccept = cycle;
                    firstLen    = int'(expLen);
                end
                expQ.push_back(expResp);
            end
            pendingCnt = expQ.size();

            if (finalize && !reported) begin
                if (expQ.size() != 0) begin
                    $display("%0d response(s) never arrived", expQ.size());
                    failCount += expQ.size();
                end
                if (!sawFull) begin
                    $display("queueFull never rose during the burst");
                    failCount++;
                end
                $display("Tests: %0d passed, %0d failed", passCount, failCount);
                reported = 1'b1;
            end
        end
    end

endmodule

// ==== tests/memSubsysTb.sv ====
`timescale 1ns/1ps
`include "memSubsys_config.svh"

module memSubsysTb import memPkg::*; ();

    localparam int NumRows   = 24;
    localparam int IdleLimit = (`QUEUE_DEPTH + 1) * 12 + 8;

    typedef struct packed {
        logic               isStore;
        logic [`ADDR_W-1:0] addr;
        logic [`LEN_W-1:0]  len;
        logic               useRand;
        logic [`DATA_W-1:0] data;
        logic [7:0]         gap;          // Cycles of rdy low.
        logic               backToBack;
    } stimRow_t;

    logic              clk;
    logic              rst;
    logic              rdy;
    logic              reqEn;
    memReq_t           req;
    logic              queueFull;
    logic              respEn;
    memResp_t          resp;

    logic              expEn;
    memResp_t          expResp;
    logic [`LEN_W-1:0] expLen;
    logic              finalize;
    int                pending;
    int                errCount;
    logic              reportDone;

    stimRow_t    stim [NumRows];
    logic [7:0]  refMem [`RAM_BYTES];
    logic [31:0] lcgState = 32'd82;
    int          runLimit = 0;

    memSubsys i_dut (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .reqEn     (reqEn),
        .req       (req),
        .queueFull (queueFull),
        .respEn    (respEn),
        .resp      (resp)
    );

    memSubsysChecker chk (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .queueFull  (queueFull),
        .respEn     (respEn),
        .resp       (resp),
        .expEn      (expEn),
        .expResp    (expResp),
        .expLen     (expLen),
        .finalize   (finalize),
        .pending    (pending),
        .errCount   (errCount),
        .reportDone (reportDone)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic buildTable();
        stim[0]  = '{1'b1, 17'h00100, 3'd4, 1'b0, 32'hDEADBEEF, 8'd0, 1'b0};  // Lone store.
        stim[1]  = '{1'b0, 17'h00100, 3'd4, 1'b0, 32'h0, 8'd0, 1'b0};
        stim[2]  = '{1'b1, 17'h00200, 3'd4, 1'b0, 32'h11223344, 8'd0, 1'b0};
        stim[3]  = '{1'b1, 17'h00201, 3'd1, 1'b0, 32'h000000AA, 8'd0, 1'b0};
        stim[4]  = '{1'b1, 17'h00202, 3'd2, 1'b0, 32'h0000BBCC, 8'd0, 1'b0};
        stim[5]  = '{1'b0, 17'h00200, 3'd4, 1'b0, 32'h0, 8'd0, 1'b0};          // Merged word.
        stim[6]  = '{1'b0, 17'h00203, 3'd1, 1'b0, 32'h0, 8'd0, 1'b0};
        stim[7]  = '{1'b0, 17'h00201, 3'd2, 1'b0, 32'h0, 8'd0, 1'b0};
        stim[8]  = '{1'b1, 17'h1FFFC, 3'd4, 1'b1, 32'h0, 8'd0, 1'b0};          // Top of RAM.
        stim[9]  = '{1'b0, 17'h1FFFC, 3'd4, 1'b0, 32'h0, 8'd0, 1'b0};
        stim[10] = '{1'b0, 17'h1FFFE, 3'd2, 1'b0, 32'h0, 8'd0, 1'b0};
        stim[11] = '{1'b1, 17'h00300, 3'd4, 1'b1, 32'h0, 8'd0, 1'b1};          // Burst of five.
        stim[12] = '{1'b1, 17'h00304, 3'd2, 1'b1, 32'h0, 8'd0, 1'b1};
        stim[13] = '{1'b0, 17'h00300, 3'd4, 1'b0, 32'h0, 8'd0, 1'b1};
        stim[14] = '{1'b1, 17'h00306, 3'd2, 1'b1, 32'h0, 8'd0, 1'b1};
        stim[15] = '{1'b0, 17'h00304, 3'd4, 1'b0, 32'h0, 8'd0, 1'b0};
        stim[16] = '{1'b1, 17'h00400, 3'd4, 1'b1, 32'h0, 8'd3, 1'b0};          // Stalls.
        stim[17] = '{1'b0, 17'h00400, 3'd4, 1'b0, 32'h0, 8'd5, 1'b0};
        stim[18] = '{1'b0, 17'h00402, 3'd2, 1'b0, 32'h0, 8'd1, 1'b0};
        stim[19] = '{1'b1, 17'h00401, 3'd1, 1'b1, 32'h0, 8'd2, 1'b1};
        stim[20] = '{1'b0, 17'h00400, 3'd4, 1'b0, 32'h0, 8'd4, 1'b0};
        stim[21] = '{1'b1, 17'h00500, 3'd4, 1'b1, 32'h0, 8'd0, 1'b1};
        stim[22] = '{1'b0, 17'h00500, 3'd1, 1'b0, 32'h0, 8'd0, 1'b1};
        stim[23] = '{1'b0, 17'h00100, 3'd4, 1'b0, 32'h0, 8'd0, 1'b0};
    endtask

    task automatic waitIdle(input int limit);
        int n;
        n = 0;
        while (pending != 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic applyRow(input int i);
        stimRow_t           row;
        logic [`DATA_W-1:0] value;
        logic [`DATA_W-1:0] expData;
        logic [`ADDR_W-1:0] a;
        int                 k;
        row     = stim[i];
        value   = row.useRand ? lcgNext() : row.data;
        expData = '0;
        // Little endian, byte k at addr+k.
        for (k = 0; k < int'(row.len); k++) begin
            a = row.addr + `ADDR_W'(k);
            if (row.isStore) begin
                refMem[a] = value[k*8 +: 8];
            end else begin
                expData[k*8 +: 8] = refMem[a];
            end
        end

        while (queueFull) begin
            @(negedge clk);
        end
        req     = '{row.isStore, row.addr, value, row.len, `TAG_W'(i)};
        reqEn   = 1'b1;
        expResp = '{expData, `TAG_W'(i)};
        expLen  = row.len;
        expEn   = 1'b1;
        @(negedge clk);
        reqEn = 1'b0;
        expEn = 1'b0;

        if (row.gap != 8'd0) begin
            repeat (2) @(negedge clk);   // Lands inside the transfer.
            rdy = 1'b0;
            repeat (int'(row.gap)) @(negedge clk);
            rdy = 1'b1;
        end
        if (!row.backToBack) begin
            waitIdle(IdleLimit + int'(row.gap));
        end
    endtask

    initial begin
        int totalGap;
        int i;
        rst      = 1'b1;
        rdy      = 1'b1;
        reqEn    = 1'b0;
        req      = '0;
        expEn    = 1'b0;
        expResp  = '0;
        expLen   = '0;
        finalize = 1'b0;

        buildTable();
        totalGap = 0;
        for (i = 0; i < NumRows; i++) begin
            totalGap += int'(stim[i].gap);
        end
        runLimit = NumRows * (4 + 4 + `QUEUE_DEPTH * 8) + totalGap + 200;

        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        for (i = 0; i < NumRows; i++) begin
            applyRow(i);
        end
        waitIdle(IdleLimit);
        repeat (2) @(negedge clk);

        finalize = 1'b1;
        wait (reportDone);
        @(negedge clk);
        if (errCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog on the whole run.
    initial begin
        int cycles;
        cycles = 0;
        @(negedge rst);
        while (cycles < runLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the run did not finish", cycles);
        $display("test failed");
        $finish;
    end

endmodule

// ==== memSubsys.f ====
+incdir+logic
logic/memPkg.sv
logic/loadStoreQueue.sv
logic/dataPort.sv
logic/memCtrl.sv
logic/byteRam.sv
logic/memSubsys.sv
tests/memSubsysChecker.sv
tests/memSubsysTb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
    --top-module memSubsysTb \
    -f memSubsys.f \
    -o memSubsysSim

./obj_dir/memSubsysSim > sim.log 2>&1
cat sim.log

if grep -qx "test passed" sim.log; then
    exit 0
else
    exit 1
fi
